/* logic/lsu_axi_pkg.sv */
package lsu_axi_pkg;

    // byte address, wraps modulo 1024
    typedef logic [9:0]  addr_t;

    // axi id doubles as the table entry index
    typedef logic [3:0]  axi_id_t;

    // lsu command tag
    typedef logic [7:0]  lsu_tag_t;

    // one read beat
    typedef logic [63:0] data_t;

    // axi burst fields
    typedef logic [7:0]  len_t;
    typedef logic [2:0]  size_t;
    typedef logic [1:0]  burst_t;
    typedef logic [1:0]  resp_t;

    // 16 << code for codes 0..4, codes 5..7 give 256
    typedef logic [2:0]  stride_code_t;

    // sub-request count, number of bursts is count + 1
    typedef logic [3:0]  count_t;

    // outstanding read table size
    localparam int NUM_IDS = 16;

    // smallest stride in bytes
    localparam int STRIDE_BASE = 16;

    // stride generator states
    typedef enum logic {
        GEN_IDLE,
        GEN_ISSUE
    } gen_state_e;

endpackage

/* logic/ar_req_if.sv */
`timescale 1ns/1ps

interface ar_req_if;
    import lsu_axi_pkg::*;

    logic   vld;
    logic   rdy;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;

    // stride generator side
    modport gen (
        output vld, addr, len, size, burst,
        input  rdy
    );

    // id tracker side
    modport trk (
        input  vld, addr, len, size, burst,
        output rdy
    );

endinterface

/* logic/ar_stride_gen.sv */
`timescale 1ns/1ps

module ar_stride_gen (
    input  logic                       clk,
    input  logic                       rst_n,
    input  lsu_axi_pkg::addr_t         lsu_araddr,
    input  lsu_axi_pkg::len_t          lsu_arlen,
    input  lsu_axi_pkg::size_t         lsu_arsize,
    input  lsu_axi_pkg::burst_t        lsu_arburst,
    input  lsu_axi_pkg::stride_code_t  lsu_arstr,
    input  lsu_axi_pkg::count_t        lsu_arnum,
    input  lsu_axi_pkg::lsu_tag_t      lsu_artag,
    input  logic                       lsu_arvld,
    output logic                       lsu_arrdy,
    output lsu_axi_pkg::lsu_tag_t      tag,
    ar_req_if.gen                      req
);
    import lsu_axi_pkg::*;

    gen_state_e state;
    gen_state_e state_nxt;
    count_t     remain;
    addr_t      addr_q;
    addr_t      stride_q;
    len_t       len_q;
    size_t      size_q;
    burst_t     burst_q;
    lsu_tag_t   tag_q;
    logic       cmd_acc;
    logic       sub_xfer;

    // stride code to byte offset
    function automatic addr_t stride_bytes(input stride_code_t code);
        if (code > 3'd4) begin
            return addr_t'(STRIDE_BASE << 4);
        end
        return addr_t'(STRIDE_BASE << code);
    endfunction

    assign lsu_arrdy = (state == GEN_IDLE);
    assign cmd_acc   = lsu_arvld & lsu_arrdy;
    assign sub_xfer  = req.vld & req.rdy;

    always_comb begin
        state_nxt = state;
        case (state)
            GEN_IDLE: begin
                if (cmd_acc) begin
                    state_nxt = GEN_ISSUE;
                end
            end
            GEN_ISSUE: begin
                // done once the last sub-request is taken
                if (sub_xfer && remain == '0) begin
                    state_nxt = GEN_IDLE;
                end
            end
            default: state_nxt = GEN_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= GEN_IDLE;
            remain <= '0;
        end else begin
            state <= state_nxt;
            if (cmd_acc) begin
                remain <= lsu_arnum;
            end else if (sub_xfer && remain != '0) begin
                remain <= remain - count_t'(1);
            end
        end
    end

    // command payload, address steps by the stride
    always_ff @(posedge clk) begin
        if (cmd_acc) begin
            addr_q   <= lsu_araddr;
            stride_q <= stride_bytes(lsu_arstr);
            len_q    <= lsu_arlen;
            size_q   <= lsu_arsize;
            burst_q  <= lsu_arburst;
            tag_q    <= lsu_artag;
        end else if (sub_xfer) begin
            addr_q <= addr_q + stride_q;
        end
    end

    assign req.vld   = (state == GEN_ISSUE);
    assign req.addr  = addr_q;
    assign req.len   = len_q;
    assign req.size  = size_q;
    assign req.burst = burst_q;
    assign tag       = tag_q;

endmodule

/* logic/axi_id_tracker.sv */
`timescale 1ns/1ps

module axi_id_tracker (
    input  logic                   clk,
    input  logic                   rst_n,
    ar_req_if.trk                  req,
    input  lsu_axi_pkg::lsu_tag_t  tag,
    output lsu_axi_pkg::axi_id_t   arid,
    output lsu_axi_pkg::addr_t     araddr,
    output lsu_axi_pkg::len_t      arlen,
    output lsu_axi_pkg::size_t     arsize,
    output lsu_axi_pkg::burst_t    arburst,
    output logic                   arvalid,
    input  logic                   arready,
    input  logic                   free_vld,
    input  lsu_axi_pkg::axi_id_t   free_id,
    input  lsu_axi_pkg::axi_id_t   lookup_id,
    output lsu_axi_pkg::lsu_tag_t  lookup_tag
);
    import lsu_axi_pkg::*;

    logic [NUM_IDS-1:0] busy;
    logic [NUM_IDS-1:0] busy_nxt;
    logic [NUM_IDS-1:0] alloc_ptr;
    logic [NUM_IDS-1:0] alloc_en;
    logic [NUM_IDS-1:0] free_mask;
    lsu_tag_t           tag_mem [NUM_IDS];
    axi_id_t            alloc_id;
    logic               alloc_ok;
    logic               xfer;
    logic               ar_sent;

    // one-hot pointer to entry index
    always_comb begin
        alloc_id = '0;
        for (int i = 0; i < NUM_IDS; i++) begin
            if (alloc_ptr[i]) begin
                alloc_id = alloc_id | axi_id_t'(i);
            end
        end
    end

    // entry under the pointer must be idle
    assign alloc_ok = |(alloc_ptr & ~busy);

    // no new sub-request while an AR is still pending
    assign req.rdy = alloc_ok & ~arvalid;
    assign xfer    = req.vld & req.rdy;
    assign ar_sent = arvalid & arready;

    assign alloc_en  = {NUM_IDS{xfer}} & alloc_ptr;
    assign free_mask = {NUM_IDS{free_vld}} & (NUM_IDS'(1) << free_id);
    assign busy_nxt  = alloc_en | (busy & ~free_mask);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= '0;
            alloc_ptr <= NUM_IDS'(1);
        end else begin
            busy <= busy_nxt;
            if (xfer) begin
                alloc_ptr <= {alloc_ptr[NUM_IDS-2:0], alloc_ptr[NUM_IDS-1]};
            end
        end
    end

    // tag per entry, written on allocation
    always_ff @(posedge clk) begin
        if (xfer) begin
            tag_mem[alloc_id] <= tag;
        end
    end

    assign lookup_tag = tag_mem[lookup_id];

    // AR output register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
        end else if (xfer) begin
            arvalid <= 1'b1;
        end else if (ar_sent) begin
            arvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            arid    <= alloc_id;
            araddr  <= req.addr;
            arlen   <= req.len;
            arsize  <= req.size;
            arburst <= req.burst;
        end
    end

endmodule

/* logic/r_resp_buf.sv */
`timescale 1ns/1ps

module r_resp_buf (
    input  logic                   clk,
    input  logic                   rst_n,
    input  lsu_axi_pkg::axi_id_t   rid,
    input  lsu_axi_pkg::data_t     rdata,
    input  lsu_axi_pkg::resp_t     rresp,
    input  logic                   rlast,
    input  logic                   rvalid,
    output logic                   rready,
    output lsu_axi_pkg::axi_id_t   lookup_id,
    input  lsu_axi_pkg::lsu_tag_t  lookup_tag,
    output lsu_axi_pkg::lsu_tag_t  lsu_rtag,
    output lsu_axi_pkg::data_t     lsu_rdata,
    output lsu_axi_pkg::resp_t     lsu_rresp,
    output logic                   lsu_rlast,
    output logic                   lsu_rvld,
    input  logic                   lsu_rrdy,
    output logic                   free_vld,
    output lsu_axi_pkg::axi_id_t   free_id
);
    import lsu_axi_pkg::*;

    logic    full;
    axi_id_t rid_q;
    logic    r_acc;
    logic    lsu_acc;

    assign rready  = ~full;
    assign r_acc   = rvalid & rready;
    assign lsu_acc = full & lsu_rrdy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (r_acc) begin
            full <= 1'b1;
        end else if (lsu_acc) begin
            full <= 1'b0;
        end
    end

    // beat payload
    always_ff @(posedge clk) begin
        if (r_acc) begin
            rid_q     <= rid;
            lsu_rdata <= rdata;
            lsu_rresp <= rresp;
            lsu_rlast <= rlast;
        end
    end

    // tag comes back from the tracker table
    assign lookup_id = rid_q;
    assign lsu_rtag  = lookup_tag;
    assign lsu_rvld  = full;

    // entry freed when the last beat leaves
    assign free_vld = lsu_acc & lsu_rlast;
    assign free_id  = rid_q;

endmodule

/* logic/axi_read_intf.sv */
`timescale 1ns/1ps

module axi_read_intf (
    input  logic                       clk,
    input  logic                       rst_n,
    // lsu command
    input  lsu_axi_pkg::addr_t         lsu_araddr,
    input  lsu_axi_pkg::len_t          lsu_arlen,
    input  lsu_axi_pkg::size_t         lsu_arsize,
    input  lsu_axi_pkg::burst_t        lsu_arburst,
    input  lsu_axi_pkg::stride_code_t  lsu_arstr,
    input  lsu_axi_pkg::count_t        lsu_arnum,
    input  lsu_axi_pkg::lsu_tag_t      lsu_artag,
    input  logic                       lsu_arvld,
    output logic                       lsu_arrdy,
    // lsu response
    output lsu_axi_pkg::lsu_tag_t      lsu_rtag,
    output lsu_axi_pkg::data_t         lsu_rdata,
    output lsu_axi_pkg::resp_t         lsu_rresp,
    output logic                       lsu_rlast,
    output logic                       lsu_rvld,
    input  logic                       lsu_rrdy,
    // axi read address
    output lsu_axi_pkg::addr_t         araddr,
    output lsu_axi_pkg::axi_id_t       arid,
    output lsu_axi_pkg::len_t          arlen,
    output lsu_axi_pkg::size_t         arsize,
    output lsu_axi_pkg::burst_t        arburst,
    output logic                       arvalid,
    input  logic                       arready,
    // axi read data
    input  lsu_axi_pkg::axi_id_t       rid,
    input  lsu_axi_pkg::data_t         rdata,
    input  lsu_axi_pkg::resp_t         rresp,
    input  logic                       rlast,
    input  logic                       rvalid,
    output logic                       rready
);
    import lsu_axi_pkg::*;

    lsu_tag_t gen_tag;
    logic     free_vld;
    axi_id_t  free_id;
    axi_id_t  lookup_id;
    lsu_tag_t lookup_tag;

    ar_req_if req_bus ();

    ar_stride_gen u_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .lsu_araddr  (lsu_araddr),
        .lsu_arlen   (lsu_arlen),
        .lsu_arsize  (lsu_arsize),
        .lsu_arburst (lsu_arburst),
        .lsu_arstr   (lsu_arstr),
        .lsu_arnum   (lsu_arnum),
        .lsu_artag   (lsu_artag),
        .lsu_arvld   (lsu_arvld),
        .lsu_arrdy   (lsu_arrdy),
        .tag         (gen_tag),
        .req         (req_bus.gen)
    );

    axi_id_tracker u_trk (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req_bus.trk),
        .tag        (gen_tag),
        .arid       (arid),
        .araddr     (araddr),
        .arlen      (arlen),
        .arsize     (arsize),
        .arburst    (arburst),
        .arvalid    (arvalid),
        .arready    (arready),
        .free_vld   (free_vld),
        .free_id    (free_id),
        .lookup_id  (lookup_id),
        .lookup_tag (lookup_tag)
    );

    r_resp_buf u_rbuf (
        .clk        (clk),
        .rst_n      (rst_n),
        .rid        (rid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .rready     (rready),
        .lookup_id  (lookup_id),
        .lookup_tag (lookup_tag),
        .lsu_rtag   (lsu_rtag),
        .lsu_rdata  (lsu_rdata),
        .lsu_rresp  (lsu_rresp),
        .lsu_rlast  (lsu_rlast),
        .lsu_rvld   (lsu_rvld),
        .lsu_rrdy   (lsu_rrdy),
        .free_vld   (free_vld),
        .free_id    (free_id)
    );

endmodule

/* dv/axi_read_assert.sv */
`timescale 1ns/1ps

module axi_read_assert (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lsu_axi_pkg::addr_t    araddr,
    input  lsu_axi_pkg::axi_id_t  arid,
    input  lsu_axi_pkg::len_t     arlen,
    input  lsu_axi_pkg::size_t    arsize,
    input  lsu_axi_pkg::burst_t   arburst,
    input  logic                  arvalid,
    input  logic                  arready,
    input  logic                  rready,
    input  logic                  lsu_rvld,
    input  logic                  free_vld,
    input  lsu_axi_pkg::axi_id_t  free_id
);
    import lsu_axi_pkg::*;

    logic [NUM_IDS-1:0] in_flight;
    logic [NUM_IDS-1:0] set_mask;
    logic [NUM_IDS-1:0] clr_mask;
    int                 fail_count = 0;

    // ids between AR handshake and release
    assign set_mask = (arvalid && arready) ? (NUM_IDS'(1) << arid) : '0;
    assign clr_mask = free_vld ? (NUM_IDS'(1) << free_id) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_flight <= '0;
        end else begin
            in_flight <= (in_flight & ~clr_mask) | set_mask;
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable({araddr, arid, arlen, arsize, arburst}))
        else begin
            fail_count++;
            $error("AR channel changed while waiting for arready");
        end

    a_rready_off: assert property (@(posedge clk) disable iff (!rst_n)
        lsu_rvld |-> !rready)
        else begin
            fail_count++;
            $error("rready high while the response buffer is full");
        end

    a_reset_low: assert property (@(posedge clk)
        !rst_n |=> !arvalid && !lsu_rvld)
        else begin
            fail_count++;
            $error("arvalid or lsu_rvld high during reset");
        end

    a_id_unique: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && arready |-> !in_flight[arid])
        else begin
            fail_count++;
            $error("arid reused while still outstanding");
        end

endmodule

bind axi_read_intf axi_read_assert u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .araddr   (araddr),
    .arid     (arid),
    .arlen    (arlen),
    .arsize   (arsize),
    .arburst  (arburst),
    .arvalid  (arvalid),
    .arready  (arready),
    .rready   (rready),
    .lsu_rvld (lsu_rvld),
    .free_vld (free_vld),
    .free_id  (free_id)
);

/* dv/tb_axi_read_intf.sv */
`timescale 1ns/1ps

module tb_axi_read_intf;
    import lsu_axi_pkg::*;

    localparam int NUM_CMDS  = 53;
    localparam int MAX_BEATS = 64;

    typedef struct packed {
        addr_t    addr;
        len_t     len;
        size_t    size;
        burst_t   burst;
        axi_id_t  id;
        lsu_tag_t tag;
    } ar_t;

    typedef struct packed {
        data_t    data;
        resp_t    resp;
        logic     last;
        lsu_tag_t tag;
    } beat_t;

    logic         clk = 1'b0;
    logic         rst_n;
    addr_t        lsu_araddr, araddr;
    len_t         lsu_arlen, arlen;
    size_t        lsu_arsize, arsize;
    burst_t       lsu_arburst, arburst;
    stride_code_t lsu_arstr;
    count_t       lsu_arnum;
    lsu_tag_t     lsu_artag, lsu_rtag;
    logic         lsu_arvld, lsu_arrdy, lsu_rlast, lsu_rvld, lsu_rrdy;
    data_t        lsu_rdata, rdata;
    resp_t        lsu_rresp, rresp;
    axi_id_t      arid, rid;
    logic         arvalid, arready, rlast, rvalid, rready;

    logic [31:0] lcg_state = 32'd85;
    ar_t         exp_ar[$];
    ar_t         slave_q[$];
    beat_t       exp_beat[$];
    int          ar_total = 0;
    int          in_flight = 0;
    int          beat_idx = 0;
    int          err_count = 0;
    int          check_count = 0;
    int          test_count = 0;
    int          test_err_start = 0;
    string       cur_test = "none";
    logic        rand_bp = 1'b0;
    logic        hold_r = 1'b0;

    axi_read_intf i_dut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    // lcg step, result reduced below n
    function automatic logic [15:0] rand_below(input logic [15:0] n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16] % n;
    endfunction

    function automatic addr_t stride_of(input stride_code_t code);
        case (code)
            3'd0: return 10'd16;
            3'd1: return 10'd32;
            3'd2: return 10'd64;
            3'd3: return 10'd128;
            default: return 10'd256;
        endcase
    endfunction

    function automatic data_t beat_data(input addr_t a, input len_t idx, input axi_id_t id);
        return {16'hbeef, 26'd0, a, idx, id};
    endfunction

    // SLVERR in the upper half of the address space
    function automatic resp_t resp_for(input addr_t a);
        return a[9] ? 2'b10 : 2'b00;
    endfunction

    task automatic report_mismatch(input string field, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("MISMATCH %s %s: expected %0h, actual %0h", cur_test, field, exp, act);
        err_count++;
    endtask

    task automatic report_error(input string what);
        $display("ERROR %s: %s", cur_test, what);
        err_count++;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err_start = err_count;
    endtask

    task automatic end_test();
        test_count++;
        $display("test %s %s, %0d errors", cur_test,
                 (err_count == test_err_start) ? "passed" : "failed",
                 err_count - test_err_start);
    endtask

    task automatic check_ar();
        ar_t     e;
        axi_id_t exp_id;
        check_count++;
        // ids are handed out in sequence from reset, one per AR
        exp_id = axi_id_t'(ar_total % NUM_IDS);
        ar_total++;
        if (exp_ar.size() == 0) begin
            report_error("AR issued with no command waiting for it");
            return;
        end
        e = exp_ar.pop_front();
        e.id = exp_id;
        if (araddr !== e.addr) report_mismatch("araddr", 64'(e.addr), 64'(araddr));
        if (arlen !== e.len) report_mismatch("arlen", 64'(e.len), 64'(arlen));
        if (arsize !== e.size) report_mismatch("arsize", 64'(e.size), 64'(arsize));
        if (arburst !== e.burst) report_mismatch("arburst", 64'(e.burst), 64'(arburst));
        if (arid !== e.id) report_mismatch("arid", 64'(e.id), 64'(arid));
        in_flight++;
        if (in_flight > NUM_IDS) report_error("more than 16 reads outstanding at the slave");
        slave_q.push_back(ar_t'{araddr, arlen, arsize, arburst, arid, 8'h00});
        for (int b = 0; b <= int'(e.len); b++) begin
            exp_beat.push_back(beat_t'{beat_data(e.addr, len_t'(b), e.id), resp_for(e.addr),
                                       b == int'(e.len), e.tag});
        end
    endtask

    task automatic check_beat();
        beat_t e;
        check_count++;
        if (exp_beat.size() == 0) begin
            report_error("LSU received a beat that no AR asked for");
            return;
        end
        e = exp_beat.pop_front();
        if (lsu_rdata !== e.data) report_mismatch("lsu_rdata", e.data, lsu_rdata);
        if (lsu_rresp !== e.resp) report_mismatch("lsu_rresp", 64'(e.resp), 64'(lsu_rresp));
        if (lsu_rlast !== e.last) report_mismatch("lsu_rlast", 64'(e.last), 64'(lsu_rlast));
        if (lsu_rtag !== e.tag) report_mismatch("lsu_rtag", 64'(e.tag), 64'(lsu_rtag));
        if (lsu_rlast) in_flight--;
    endtask

    // slave outputs, called just after the clock edge
    task automatic drive_slave(input logic r_done);
        ar_t s;
        arready  = rand_bp ? (rand_below(16'd2) == 16'd0) : 1'b1;
        lsu_rrdy = rand_bp ? (rand_below(16'd4) != 16'd0) : 1'b1;
        if (r_done) begin
            beat_idx++;
            if (beat_idx > int'(slave_q[0].len)) begin
                void'(slave_q.pop_front());
                beat_idx = 0;
            end
        end
        if (rvalid && !r_done) begin
            // beat held until rready
        end else if (slave_q.size() != 0 && !hold_r &&
                     (!rand_bp || rand_below(16'd3) != 16'd0)) begin
            s      = slave_q[0];
            rvalid = 1'b1;
            rid    = s.id;
            rdata  = beat_data(s.addr, len_t'(beat_idx), s.id);
            rresp  = resp_for(s.addr);
            rlast  = (beat_idx == int'(s.len));
        end else begin
            rvalid = 1'b0;
        end
    endtask

    // handshakes are sampled at the falling edge, before the edge that completes them
    initial begin : slave_model
        logic ar_hs;
        logic r_hs;
        forever begin
            @(negedge clk);
            ar_hs = arvalid && arready;
            r_hs  = rvalid && rready;
            if (rst_n && ar_hs) check_ar();
            if (rst_n && lsu_rvld && lsu_rrdy) check_beat();
            @(posedge clk);
            #1;
            drive_slave(rst_n && r_hs);
        end
    end

    task automatic send_cmd(input addr_t base, input len_t len, input size_t size,
                            input burst_t burst, input stride_code_t code,
                            input count_t num, input lsu_tag_t tag);
        addr_t stride;
        stride = stride_of(code);
        for (int k = 0; k <= int'(num); k++) begin
            exp_ar.push_back(ar_t'{base + addr_t'(k) * stride, len, size, burst, 4'd0, tag});
        end
        lsu_araddr  = base;
        lsu_arlen   = len;
        lsu_arsize  = size;
        lsu_arburst = burst;
        lsu_arstr   = code;
        lsu_arnum   = num;
        lsu_artag   = tag;
        lsu_arvld   = 1'b1;
        do @(negedge clk); while (!lsu_arrdy);
        @(posedge clk);
        #1;
        lsu_arvld = 1'b0;
    endtask

    task automatic send_random_cmd();
        send_cmd(addr_t'(rand_below(16'd1024)), len_t'(rand_below(16'd4)),
                 size_t'(rand_below(16'd4)), burst_t'(rand_below(16'd3)),
                 stride_code_t'(rand_below(16'd8)), count_t'(rand_below(16'd4)),
                 lsu_tag_t'(rand_below(16'd256)));
    endtask

    task automatic wait_drain();
        while (exp_ar.size() != 0 || exp_beat.size() != 0) @(posedge clk);
        @(posedge clk);
        #1;
    endtask

    initial begin : watchdog
        repeat (NUM_CMDS * MAX_BEATS * 40) @(posedge clk);
        $display("TIMEOUT in %s: transfers stopped completing", cur_test);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main_seq
        int start;
        rst_n       = 1'b0;
        lsu_araddr  = '0;
        lsu_arlen   = '0;
        lsu_arsize  = '0;
        lsu_arburst = '0;
        lsu_arstr   = '0;
        lsu_arnum   = '0;
        lsu_artag   = '0;
        lsu_arvld   = 1'b0;
        lsu_rrdy    = 1'b0;
        arready     = 1'b0;
        rid         = '0;
        rdata       = '0;
        rresp       = '0;
        rlast       = 1'b0;
        rvalid      = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        start_test("reset_state");
        check_count += 4;
        if (lsu_arrdy !== 1'b1) report_mismatch("lsu_arrdy", 64'd1, 64'(lsu_arrdy));
        if (arvalid !== 1'b0) report_mismatch("arvalid", 64'd0, 64'(arvalid));
        if (lsu_rvld !== 1'b0) report_mismatch("lsu_rvld", 64'd0, 64'(lsu_rvld));
        if (rready !== 1'b1) report_mismatch("rready", 64'd1, 64'(rready));
        end_test();

        start_test("single_burst");
        start = ar_total;
        send_cmd(10'h040, 8'd3, 3'd3, 2'b01, 3'd0, 4'd0, 8'h5a);
        wait_drain();
        check_count++;
        if (ar_total - start != 1) report_mismatch("ar count", 64'd1, 64'(ar_total - start));
        end_test();

        start_test("stride");
        for (int c = 0; c < 8; c++) begin
            send_cmd(addr_t'(rand_below(16'd1024)), len_t'(rand_below(16'd2)), 3'd3, 2'b01,
                     stride_code_t'(c), count_t'(16'd1 + rand_below(16'd3)),
                     lsu_tag_t'(8'h10 + c));
        end
        wait_drain();
        end_test();

        // both walks cross the SLVERR boundary
        start_test("resp_pass");
        send_cmd(10'h3c0, 8'd1, 3'd3, 2'b01, 3'd6, 4'd3, 8'ha5);
        send_cmd(10'h1f8, 8'd2, 3'd3, 2'b01, 3'd1, 4'd2, 8'h3c);
        wait_drain();
        end_test();

        start_test("back_pressure");
        rand_bp = 1'b1;
        repeat (40) send_random_cmd();
        wait_drain();
        rand_bp = 1'b0;
        end_test();

        start_test("id_exhaust");
        start  = ar_total;
        hold_r = 1'b1;
        send_cmd(addr_t'(rand_below(16'd1024)), 8'd0, 3'd3, 2'b01, 3'd0, 4'd15, 8'hc3);
        send_cmd(addr_t'(rand_below(16'd1024)), 8'd1, 3'd3, 2'b01, 3'd2, 4'd3, 8'hc4);
        while (ar_total - start < NUM_IDS) @(posedge clk);
        repeat (40) @(posedge clk);
        check_count++;
        if (ar_total - start != NUM_IDS) begin
            report_mismatch("ars before release", 64'(NUM_IDS), 64'(ar_total - start));
        end
        @(negedge clk);
        hold_r = 1'b0;
        wait_drain();
        end_test();

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_count, check_count, err_count, i_dut.u_props.fail_count);
        if (err_count == 0 && i_dut.u_props.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
logic/lsu_axi_pkg.sv
logic/ar_req_if.sv
logic/ar_stride_gen.sv
logic/axi_id_tracker.sv
logic/r_resp_buf.sv
logic/axi_read_intf.sv
dv/axi_read_assert.sv
dv/tb_axi_read_intf.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         ?= tb_axi_read_intf
FILELIST    ?= project.f
OBJ_DIR     ?= obj_dir
VFLAGS      ?= --binary --timing --assert
ERROR_LIMIT ?= 100
PASS_MSG    := >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS ERROR_LIMIT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
